//--- all.f
design/decode_pkg.sv
design/instr_decoder.sv
design/operand_select.sv
design/fence_tracker.sv
design/wb_port_scheduler.sv
design/issue_latch.sv
design/decode_stage.sv
verification/decode_stage_tb.sv

//--- design/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // datapath widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int OP_W      = 4;

  // write-back booking, slot k is the port k+1 cycles after issue
  localparam int WB_SCHED_DEPTH   = 19;
  localparam int ALU_WB_SLOT      = 0;
  localparam int MUL_WB_SLOT      = 3;
  localparam int DIV_WB_SLOT      = 17;
  localparam int DIV_FAST_WB_SLOT = 0;

  typedef logic [XLEN-1:0]           word_t;
  typedef logic [REG_IDX_W-1:0]      reg_idx_t;
  typedef logic [OP_W-1:0]           unit_op_t;
  typedef logic [WB_SCHED_DEPTH-1:0] wb_sched_t;

  // divide operands that finish early
  localparam word_t DIV_MIN_DIVIDEND = 32'h8000_0000;
  localparam word_t DIV_ALL_ONES     = 32'hffff_ffff;

  // funct fields that steer the decode
  localparam logic [6:0] FUNCT7_MULDIV  = 7'b0000001;
  localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SRX     = 3'b101;
  localparam unit_op_t   ALU_OP_ADD     = 4'b0000;

  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111
  } opcode_t;

  typedef enum logic [2:0] {
    FU_NONE,
    FU_ARITH,
    FU_MUL,
    FU_DIV,
    FU_LS
  } fu_t;

  typedef enum logic [1:0] {
    SRC_A_RS1,
    SRC_A_PC,
    SRC_A_ZERO
  } src_a_t;

  typedef enum logic {
    SRC_B_RS2,
    SRC_B_IMM
  } src_b_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  typedef struct packed {
    logic  rs1_ena;
    word_t rs1_data;
    logic  rs2_ena;
    word_t rs2_data;
  } bypass_t;

  typedef struct packed {
    logic arith;
    logic mul;
    logic div;
    logic ls;
  } unit_stall_t;

  typedef struct packed {
    fu_t      fu;
    unit_op_t op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    src_a_t   src_a;
    src_b_t   src_b;
    word_t    imm;
    logic     is_fence;
  } decoded_t;

  typedef struct packed {
    word_t port_a;
    word_t port_b;
    word_t store_data;
  } operands_t;

  typedef struct packed {
    logic     valid;
    unit_op_t op;
    reg_idx_t rd;
    word_t    port_a;
    word_t    port_b;
    word_t    store_data;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t arith;
    issue_slot_t mul;
    issue_slot_t div;
    issue_slot_t ls;
  } issue_bus_t;

  typedef struct packed {
    logic icache_flush;
    logic dcache_flush;
  } cache_flush_t;

  typedef struct packed {
    logic iflush_done;
    logic dflush_done;
  } flush_done_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  decode_pkg::fetch_t       fetch,
  input  decode_pkg::word_t        rs1_data,
  input  decode_pkg::word_t        rs2_data,
  input  decode_pkg::bypass_t      bypass,
  input  decode_pkg::unit_stall_t  unit_stall,
  input  logic                     flush,
  input  decode_pkg::flush_done_t  flush_done,
  output decode_pkg::reg_idx_t     rs1,
  output decode_pkg::reg_idx_t     rs2,
  output decode_pkg::issue_bus_t   issue,
  output decode_pkg::cache_flush_t cache_flush,
  output logic                     decode_busy
);

  decode_pkg::decoded_t  dec;
  decode_pkg::operands_t ops;
  logic                  fence_busy;
  logic                  wb_conflict;
  logic                  unit_busy;
  logic                  accept;

  instr_decoder u_decoder (
    .fetch(fetch),
    .dec  (dec)
  );

  assign rs1 = dec.rs1;
  assign rs2 = dec.rs2;

  operand_select u_operands (
    .dec     (dec),
    .pc      (fetch.pc),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .bypass  (bypass),
    .ops     (ops)
  );

  // only the target unit's stall holds decode
  always_comb begin
    case (dec.fu)
      decode_pkg::FU_ARITH: unit_busy = unit_stall.arith;
      decode_pkg::FU_MUL:   unit_busy = unit_stall.mul;
      decode_pkg::FU_DIV:   unit_busy = unit_stall.div;
      decode_pkg::FU_LS:    unit_busy = unit_stall.ls;
      default:              unit_busy = 1'b0;
    endcase
  end

  assign decode_busy = fence_busy || wb_conflict || unit_busy;
  assign accept      = !flush && !decode_busy;

  fence_tracker u_fence (
    .CLK        (CLK),
    .nRST       (nRST),
    .dec        (dec),
    .accept     (accept),
    .flush_done (flush_done),
    .cache_flush(cache_flush),
    .fence_busy (fence_busy)
  );

  wb_port_scheduler u_wb_sched (
    .CLK        (CLK),
    .nRST       (nRST),
    .dec        (dec),
    .ops        (ops),
    .accept     (accept),
    .wb_conflict(wb_conflict)
  );

  issue_latch u_issue (
    .CLK       (CLK),
    .nRST      (nRST),
    .dec       (dec),
    .ops       (ops),
    .accept    (accept),
    .unit_stall(unit_stall),
    .flush     (flush),
    .issue     (issue)
  );

endmodule

`default_nettype wire

//--- design/fence_tracker.sv
`default_nettype none

module fence_tracker (
  input  logic                     CLK,
  input  logic                     nRST,
  input  decode_pkg::decoded_t     dec,
  input  logic                     accept,
  input  decode_pkg::flush_done_t  flush_done,
  output decode_pkg::cache_flush_t cache_flush,
  output logic                     fence_busy
);

  logic seen;
  logic pulse;
  logic iflushed;
  logic dflushed;

  // first cycle a fence.i sits in decode
  assign pulse = dec.is_fence && !seen;

  assign cache_flush.icache_flush = pulse;
  assign cache_flush.dcache_flush = pulse;

  assign fence_busy = dec.is_fence && (pulse || !(iflushed && dflushed));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      seen <= 1'b0;
    end else if (accept || !dec.is_fence) begin
      // also drops a fence that was flushed away before it left
      seen <= 1'b0;
    end else if (pulse) begin
      seen <= 1'b1;
    end
  end

  // done bits are levels, each may come back on its own cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (pulse) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      if (flush_done.iflush_done) begin
        iflushed <= 1'b1;
      end
      if (flush_done.dflush_done) begin
        dflushed <= 1'b1;
      end
    end
  end

  // one fence.i gives exactly one flush request
  assert property (@(posedge CLK) disable iff (!nRST) pulse |=> !pulse)
    else $error("cache flush request held longer than one cycle");

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`default_nettype none

module instr_decoder (
  input  decode_pkg::fetch_t   fetch,
  output decode_pkg::decoded_t dec
);

  decode_pkg::word_t instr;
  decode_pkg::word_t imm_i;
  decode_pkg::word_t imm_s;
  decode_pkg::word_t imm_u;
  decode_pkg::word_t shamt;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              is_shift;

  assign instr  = fetch.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // immediates, all sign extended except shamt
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};
  assign shamt = {27'b0, instr[24:20]};

  assign is_shift = (funct3 == decode_pkg::FUNCT3_SLL) || (funct3 == decode_pkg::FUNCT3_SRX);

  always_comb begin
    dec          = '0;
    dec.fu       = decode_pkg::FU_NONE;
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.src_a    = decode_pkg::SRC_A_RS1;
    dec.src_b    = decode_pkg::SRC_B_RS2;
    case (instr[6:0])
      decode_pkg::OPC_LUI: begin
        dec.fu    = decode_pkg::FU_ARITH;
        dec.op    = decode_pkg::ALU_OP_ADD;
        dec.rd    = instr[11:7];
        dec.src_a = decode_pkg::SRC_A_ZERO;
        dec.src_b = decode_pkg::SRC_B_IMM;
        dec.imm   = imm_u;
      end
      decode_pkg::OPC_AUIPC: begin
        dec.fu    = decode_pkg::FU_ARITH;
        dec.op    = decode_pkg::ALU_OP_ADD;
        dec.rd    = instr[11:7];
        dec.src_a = decode_pkg::SRC_A_PC;
        dec.src_b = decode_pkg::SRC_B_IMM;
        dec.imm   = imm_u;
      end
      decode_pkg::OPC_OP: begin
        dec.rd = instr[11:7];
        if (funct7 == decode_pkg::FUNCT7_MULDIV) begin
          // funct3[2] splits multiply from divide/remainder
          dec.fu = funct3[2] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
          dec.op = {1'b0, funct3};
        end else begin
          dec.fu = decode_pkg::FU_ARITH;
          dec.op = {instr[30], funct3};
        end
      end
      decode_pkg::OPC_OP_IMM: begin
        dec.fu    = decode_pkg::FU_ARITH;
        dec.rd    = instr[11:7];
        dec.src_b = decode_pkg::SRC_B_IMM;
        // bit 30 only selects srai, elsewhere it is immediate
        dec.op    = {(funct3 == decode_pkg::FUNCT3_SRX) && instr[30], funct3};
        dec.imm   = is_shift ? shamt : imm_i;
      end
      decode_pkg::OPC_LOAD: begin
        dec.fu    = decode_pkg::FU_LS;
        dec.op    = {1'b0, funct3};
        dec.rd    = instr[11:7];
        dec.src_b = decode_pkg::SRC_B_IMM;
        dec.imm   = imm_i;
      end
      decode_pkg::OPC_STORE: begin
        dec.fu    = decode_pkg::FU_LS;
        dec.op    = {1'b1, funct3};
        dec.src_b = decode_pkg::SRC_B_IMM;
        dec.imm   = imm_s;
      end
      decode_pkg::OPC_MISC_MEM: begin
        // plain fence falls through as a no-op
        dec.is_fence = (funct3 == decode_pkg::FUNCT3_FENCE_I);
      end
      default: begin
        dec.fu = decode_pkg::FU_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/issue_latch.sv
`default_nettype none

module issue_latch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  decode_pkg::decoded_t    dec,
  input  decode_pkg::operands_t   ops,
  input  logic                    accept,
  input  decode_pkg::unit_stall_t unit_stall,
  input  logic                    flush,
  output decode_pkg::issue_bus_t  issue
);

  decode_pkg::issue_slot_t fresh;
  decode_pkg::unit_stall_t load;

  // stalled slot holds, otherwise load or empty
  function automatic decode_pkg::issue_slot_t slot_next(
    input decode_pkg::issue_slot_t cur,
    input logic                    stall,
    input logic                    hit,
    input decode_pkg::issue_slot_t nxt
  );
    decode_pkg::issue_slot_t res;
    if (stall) begin
      res = cur;
    end else if (hit) begin
      res = nxt;
    end else begin
      res = '0;
    end
    return res;
  endfunction

  always_comb begin
    fresh.valid      = 1'b1;
    fresh.op         = dec.op;
    fresh.rd         = dec.rd;
    fresh.port_a     = ops.port_a;
    fresh.port_b     = ops.port_b;
    fresh.store_data = ops.store_data;
  end

  assign load.arith = accept && (dec.fu == decode_pkg::FU_ARITH);
  assign load.mul   = accept && (dec.fu == decode_pkg::FU_MUL);
  assign load.div   = accept && (dec.fu == decode_pkg::FU_DIV);
  assign load.ls    = accept && (dec.fu == decode_pkg::FU_LS);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      issue <= '0;
    end else if (flush) begin
      issue <= '0;
    end else begin
      issue.arith <= slot_next(issue.arith, unit_stall.arith, load.arith, fresh);
      issue.mul   <= slot_next(issue.mul, unit_stall.mul, load.mul, fresh);
      issue.div   <= slot_next(issue.div, unit_stall.div, load.div, fresh);
      issue.ls    <= slot_next(issue.ls, unit_stall.ls, load.ls, fresh);
    end
  end

  // one target per edge, and never a unit that is stalled
  assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(load) && !(|(load & unit_stall)))
    else $error("issue loaded more than one slot or a stalled slot");

endmodule

`default_nettype wire

//--- design/operand_select.sv
`default_nettype none

module operand_select (
  input  decode_pkg::decoded_t  dec,
  input  decode_pkg::word_t     pc,
  input  decode_pkg::word_t     rs1_data,
  input  decode_pkg::word_t     rs2_data,
  input  decode_pkg::bypass_t   bypass,
  output decode_pkg::operands_t ops
);

  decode_pkg::word_t rs1_val;
  decode_pkg::word_t rs2_val;

  // forwarded results win over the register file
  assign rs1_val = bypass.rs1_ena ? bypass.rs1_data : rs1_data;
  assign rs2_val = bypass.rs2_ena ? bypass.rs2_data : rs2_data;

  always_comb begin
    case (dec.src_a)
      decode_pkg::SRC_A_RS1: begin
        ops.port_a = rs1_val;
      end
      decode_pkg::SRC_A_PC: begin
        ops.port_a = pc;
      end
      default: begin
        ops.port_a = '0;
      end
    endcase
  end

  always_comb begin
    case (dec.src_b)
      decode_pkg::SRC_B_IMM: begin
        ops.port_b = dec.imm;
      end
      default: begin
        ops.port_b = rs2_val;
      end
    endcase
  end

  // stores take rs2 while port b carries the offset
  assign ops.store_data = rs2_val;

endmodule

`default_nettype wire

//--- design/wb_port_scheduler.sv
`default_nettype none

module wb_port_scheduler (
  input  logic                  CLK,
  input  logic                  nRST,
  input  decode_pkg::decoded_t  dec,
  input  decode_pkg::operands_t ops,
  input  logic                  accept,
  output logic                  wb_conflict
);

  decode_pkg::wb_sched_t sched;
  decode_pkg::wb_sched_t booking;
  logic                  div_special;
  logic                  needs_port;
  int                    slot;

  // these divides skip the iterative loop
  assign div_special = (ops.port_a == decode_pkg::DIV_MIN_DIVIDEND) ||
                       (ops.port_b == decode_pkg::DIV_ALL_ONES) ||
                       (ops.port_b == '0);

  always_comb begin
    needs_port = 1'b1;
    slot       = decode_pkg::ALU_WB_SLOT;
    case (dec.fu)
      decode_pkg::FU_ARITH: begin
        slot = decode_pkg::ALU_WB_SLOT;
      end
      decode_pkg::FU_MUL: begin
        slot = decode_pkg::MUL_WB_SLOT;
      end
      decode_pkg::FU_DIV: begin
        slot = div_special ? decode_pkg::DIV_FAST_WB_SLOT : decode_pkg::DIV_WB_SLOT;
      end
      default: begin
        // load/store and no-unit instructions stay off the port
        needs_port = 1'b0;
      end
    endcase
  end

  assign wb_conflict = needs_port && sched[slot];

  assign booking = (accept && needs_port) ? (decode_pkg::wb_sched_t'(1) << slot) : '0;

  // bit 0 is the port one cycle after the current edge
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sched <= '0;
    end else begin
      sched <= (sched | booking) >> 1;
    end
  end

  // busy from the top level must hold back a colliding instruction
  assert property (@(posedge CLK) disable iff (!nRST) wb_conflict |-> !accept)
    else $error("instruction accepted onto a booked write-back slot");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
verilator --binary --timing -f all.f --top-module decode_stage_tb -o decode_stage_sim &&
  ./obj_dir/decode_stage_sim | grep "Verification passed" || exit 1

//--- verification/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 5;
  localparam int MAX_ROWS     = 96;

  // valid bits of the four issue slots
  typedef struct packed {
    logic arith;
    logic mul;
    logic div;
    logic ls;
  } slot_mask_t;

  // one cycle of stimulus and what the stage must answer
  typedef struct packed {
    decode_pkg::word_t        instr;
    decode_pkg::word_t        pc;
    decode_pkg::word_t        rs1_data;
    decode_pkg::word_t        rs2_data;
    decode_pkg::bypass_t      bypass;
    decode_pkg::unit_stall_t  stall;
    logic                     flush;
    decode_pkg::flush_done_t  done;
    logic                     exp_busy;
    decode_pkg::cache_flush_t exp_cf;
    decode_pkg::fu_t          chk_fu;
    slot_mask_t               exp_valid;
    decode_pkg::issue_slot_t  exp_slot;
  } row_t;

  logic                     CLK;
  logic                     nRST;
  decode_pkg::fetch_t       fetch;
  decode_pkg::word_t        rs1_data;
  decode_pkg::word_t        rs2_data;
  decode_pkg::bypass_t      bypass;
  decode_pkg::unit_stall_t  unit_stall;
  logic                     flush;
  decode_pkg::flush_done_t  flush_done;
  decode_pkg::reg_idx_t     rs1_idx;
  decode_pkg::reg_idx_t     rs2_idx;
  decode_pkg::issue_bus_t   issue;
  decode_pkg::cache_flush_t cache_flush;
  logic                     decode_busy;

  row_t              rows [0:MAX_ROWS-1];
  string             names [0:MAX_ROWS-1];
  int                n_rows;
  int                held;
  int                error_count;
  int                cycle_limit;
  int                cycles;
  decode_pkg::word_t w;

  decode_stage dut (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch      (fetch),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .bypass     (bypass),
    .unit_stall (unit_stall),
    .flush      (flush),
    .flush_done (flush_done),
    .rs1        (rs1_idx),
    .rs2        (rs2_idx),
    .issue      (issue),
    .cache_flush(cache_flush),
    .decode_busy(decode_busy)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    cycles = 0;
    forever @(posedge CLK) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: the table did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $fatal(1, "run stopped by the cycle limit");
      end
    end
  end

  // RV32 instruction formats
  function automatic decode_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic decode_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic decode_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic decode_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic slot_mask_t unit_bit(input decode_pkg::fu_t fu);
    slot_mask_t m;
    m = '0;
    case (fu)
      decode_pkg::FU_ARITH: m.arith = 1'b1;
      decode_pkg::FU_MUL:   m.mul = 1'b1;
      decode_pkg::FU_DIV:   m.div = 1'b1;
      decode_pkg::FU_LS:    m.ls = 1'b1;
      default:              m = '0;
    endcase
    return m;
  endfunction

  function automatic decode_pkg::issue_slot_t slot_of(input decode_pkg::issue_bus_t bus,
      input decode_pkg::fu_t fu);
    case (fu)
      decode_pkg::FU_ARITH: return bus.arith;
      decode_pkg::FU_MUL:   return bus.mul;
      decode_pkg::FU_DIV:   return bus.div;
      default:              return bus.ls;
    endcase
  endfunction

  // register values of the newest row, bypass first
  function automatic decode_pkg::word_t last_rs1();
    row_t r;
    r = rows[n_rows-1];
    return r.bypass.rs1_ena ? r.bypass.rs1_data : r.rs1_data;
  endfunction

  function automatic decode_pkg::word_t last_rs2();
    row_t r;
    r = rows[n_rows-1];
    return r.bypass.rs2_ena ? r.bypass.rs2_data : r.rs2_data;
  endfunction

  task automatic add_row(input string name, input decode_pkg::word_t instr);
    int k;
    k = n_rows;
    names[k] = name;
    rows[k] = '0;
    rows[k].instr = instr;
    rows[k].pc = 32'h0000_1000 + 32'(k * 4);
    rows[k].rs1_data = $urandom;
    rows[k].rs2_data = $urandom;
    rows[k].bypass.rs1_data = $urandom;
    rows[k].bypass.rs2_data = $urandom;
    rows[k].chk_fu = decode_pkg::FU_NONE;
    n_rows++;
  endtask

  task automatic use_data(input decode_pkg::word_t a, input decode_pkg::word_t b);
    rows[n_rows-1].rs1_data = a;
    rows[n_rows-1].rs2_data = b;
  endtask

  task automatic use_bypass(input logic ena1, input logic ena2);
    rows[n_rows-1].bypass.rs1_ena = ena1;
    rows[n_rows-1].bypass.rs2_ena = ena2;
  endtask

  // bits are arith, mul, div, ls from the left
  task automatic stall_units(input decode_pkg::unit_stall_t s);
    rows[n_rows-1].stall = s;
  endtask

  task automatic give_done(input decode_pkg::flush_done_t d);
    rows[n_rows-1].done = d;
  endtask

  task automatic raise_flush();
    rows[n_rows-1].flush = 1'b1;
  endtask

  task automatic expect_busy();
    rows[n_rows-1].exp_busy = 1'b1;
  endtask

  task automatic expect_pulse();
    rows[n_rows-1].exp_cf = 2'b11;
  endtask

  task automatic also_valid(input decode_pkg::fu_t fu);
    rows[n_rows-1].exp_valid = rows[n_rows-1].exp_valid | unit_bit(fu);
  endtask

  // store data is the bypassed rs2 for every unit
  task automatic slot_is(input decode_pkg::fu_t fu, input decode_pkg::unit_op_t op,
      input decode_pkg::reg_idx_t rd, input decode_pkg::word_t a, input decode_pkg::word_t b);
    int k;
    k = n_rows - 1;
    rows[k].chk_fu = fu;
    rows[k].exp_valid = rows[k].exp_valid | unit_bit(fu);
    rows[k].exp_slot.valid = 1'b1;
    rows[k].exp_slot.op = op;
    rows[k].exp_slot.rd = rd;
    rows[k].exp_slot.port_a = a;
    rows[k].exp_slot.port_b = b;
    rows[k].exp_slot.store_data = last_rs2();
  endtask

  // stalled slot still carries an older row
  task automatic keep_slot(input int from);
    int k;
    k = n_rows - 1;
    rows[k].chk_fu = rows[from].chk_fu;
    rows[k].exp_slot = rows[from].exp_slot;
    rows[k].exp_valid = rows[k].exp_valid | unit_bit(rows[from].chk_fu);
  endtask

  task automatic compare(input string name, input string what, input logic [127:0] expected,
      input logic [127:0] actual);
    assert (actual === expected)
      else begin
        error_count++;
        $display("** Error: [%s] %s expected %0h actual %0h", name, what, expected, actual);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
      end
  endtask

  task automatic apply_row(input row_t r);
    fetch.instr <= r.instr;
    fetch.pc <= r.pc;
    rs1_data <= r.rs1_data;
    rs2_data <= r.rs2_data;
    bypass <= r.bypass;
    unit_stall <= r.stall;
    flush <= r.flush;
    flush_done <= r.done;
  endtask

  task automatic check_slots(input int i);
    slot_mask_t seen;
    seen.arith = issue.arith.valid;
    seen.mul = issue.mul.valid;
    seen.div = issue.div.valid;
    seen.ls = issue.ls.valid;
    compare(names[i], "slot valid bits", 128'(rows[i].exp_valid), 128'(seen));
    if (rows[i].chk_fu != decode_pkg::FU_NONE) begin
      compare(names[i], "issue slot", 128'(rows[i].exp_slot),
              128'(slot_of(issue, rows[i].chk_fu)));
    end
  endtask

  task automatic build_table();
    // arithmetic decode
    add_row("add", r_type(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd5, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd5, last_rs1(), last_rs2());
    add_row("sub", r_type(7'b0100000, 5'd4, 5'd1, 3'b000, 5'd6, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b1000, 5'd6, last_rs1(), last_rs2());
    add_row("addi_negative", i_type(12'hff0, 5'd1, 3'b000, 5'd7, decode_pkg::OPC_OP_IMM));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd7, last_rs1(), 32'hffff_fff0);
    add_row("srai", i_type({7'b0100000, 5'd13}, 5'd2, 3'b101, 5'd8, decode_pkg::OPC_OP_IMM));
    slot_is(decode_pkg::FU_ARITH, 4'b1101, 5'd8, last_rs1(), 32'd13);
    add_row("slli", i_type({7'b0000000, 5'd31}, 5'd2, 3'b001, 5'd9, decode_pkg::OPC_OP_IMM));
    slot_is(decode_pkg::FU_ARITH, 4'b0001, 5'd9, last_rs1(), 32'd31);
    // bit 30 here is immediate, not an operation bit
    add_row("xori_bit30", i_type(12'h400, 5'd3, 3'b100, 5'd10, decode_pkg::OPC_OP_IMM));
    slot_is(decode_pkg::FU_ARITH, 4'b0100, 5'd10, last_rs1(), 32'h0000_0400);
    add_row("lui", u_type(20'habcde, 5'd11, decode_pkg::OPC_LUI));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd11, 32'h0, 32'habcd_e000);
    add_row("auipc", u_type(20'hfffff, 5'd12, decode_pkg::OPC_AUIPC));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd12, rows[n_rows-1].pc, 32'hffff_f000);

    // bypass over register data
    add_row("add_bypass_rs1", r_type(7'b0000000, 5'd7, 5'd6, 3'b000, 5'd13, decode_pkg::OPC_OP));
    use_bypass(1'b1, 1'b0);
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd13, last_rs1(), last_rs2());
    add_row("or_bypass_rs2", r_type(7'b0000000, 5'd8, 5'd9, 3'b110, 5'd14, decode_pkg::OPC_OP));
    use_bypass(1'b0, 1'b1);
    slot_is(decode_pkg::FU_ARITH, 4'b0110, 5'd14, last_rs1(), last_rs2());
    add_row("sw_bypass_store_data", s_type(12'h804, 5'd4, 5'd3, 3'b010));
    use_bypass(1'b1, 1'b1);
    slot_is(decode_pkg::FU_LS, 4'b1010, 5'd0, last_rs1(), 32'hffff_f804);
    add_row("lw", i_type(12'h010, 5'd2, 3'b010, 5'd15, decode_pkg::OPC_LOAD));
    slot_is(decode_pkg::FU_LS, 4'b0010, 5'd15, last_rs1(), 32'h0000_0010);

    // unit stall
    add_row("add_before_stall", r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd16, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd16, last_rs1(), last_rs2());
    held = n_rows - 1;
    add_row("lbu_arith_stalled", i_type(12'h008, 5'd1, 3'b100, 5'd17, decode_pkg::OPC_LOAD));
    stall_units(4'b1000);
    slot_is(decode_pkg::FU_LS, 4'b0100, 5'd17, last_rs1(), 32'h0000_0008);
    also_valid(decode_pkg::FU_ARITH);
    w = r_type(7'b0000000, 5'd3, 5'd4, 3'b000, 5'd18, decode_pkg::OPC_OP);
    add_row("add_arith_stalled", w);
    stall_units(4'b1000);
    expect_busy();
    keep_slot(held);
    add_row("add_stall_released", w);
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd18, last_rs1(), last_rs2());

    // multiply books slot 3
    add_row("mulh", r_type(7'b0000001, 5'd5, 5'd6, 3'b001, 5'd19, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_MUL, 4'b0001, 5'd19, last_rs1(), last_rs2());
    add_row("add_after_mul_1", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd20, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd20, last_rs1(), last_rs2());
    add_row("add_after_mul_2", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd21, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd21, last_rs1(), last_rs2());
    w = r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd22, decode_pkg::OPC_OP);
    add_row("add_mul_wb_conflict", w);
    expect_busy();
    add_row("add_mul_wb_retry", w);
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd22, last_rs1(), last_rs2());

    // ordinary divide books slot 17
    add_row("div", r_type(7'b0000001, 5'd8, 5'd7, 3'b100, 5'd23, decode_pkg::OPC_OP));
    use_data($urandom & 32'h7fff_ffff, ($urandom & 32'h7fff_fffe) | 32'h1);
    slot_is(decode_pkg::FU_DIV, 4'b0100, 5'd23, last_rs1(), last_rs2());
    for (int k = 1; k <= 16; k++) begin
      add_row("addi_behind_div", i_type(12'(k), 5'd1, 3'b000, 5'd24, decode_pkg::OPC_OP_IMM));
      slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd24, last_rs1(), 32'(k));
    end
    w = r_type(7'b0000000, 5'd3, 5'd4, 3'b000, 5'd25, decode_pkg::OPC_OP);
    add_row("add_div_wb_conflict", w);
    expect_busy();
    add_row("add_div_wb_retry", w);
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd25, last_rs1(), last_rs2());

    // divide by zero lands on slot 0, where the multiply already is
    add_row("mul_before_divu", r_type(7'b0000001, 5'd2, 5'd3, 3'b000, 5'd26, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_MUL, 4'b0000, 5'd26, last_rs1(), last_rs2());
    add_row("add_after_mul_3", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd20, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd20, last_rs1(), last_rs2());
    add_row("add_after_mul_4", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd21, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd21, last_rs1(), last_rs2());
    w = r_type(7'b0000001, 5'd9, 5'd8, 3'b101, 5'd27, decode_pkg::OPC_OP);
    add_row("divu_zero_wb_conflict", w);
    use_data($urandom, 32'h0);
    expect_busy();
    add_row("divu_zero", w);
    use_data($urandom, 32'h0);
    slot_is(decode_pkg::FU_DIV, 4'b0101, 5'd27, last_rs1(), 32'h0);
    add_row("add_after_divu_zero", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd28, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd28, last_rs1(), last_rs2());

    // fence.i with the caches answering on their own cycles
    w = i_type(12'h000, 5'd0, 3'b001, 5'd0, decode_pkg::OPC_MISC_MEM);
    add_row("fence_i_pulse", w);
    expect_busy();
    expect_pulse();
    add_row("fence_i_wait", w);
    expect_busy();
    add_row("fence_i_icache_done", w);
    give_done(2'b10);
    expect_busy();
    add_row("fence_i_wait_dcache", w);
    expect_busy();
    add_row("fence_i_dcache_done", w);
    give_done(2'b01);
    expect_busy();
    add_row("fence_i_release", w);
    add_row("fence_i_second_pulse", w);
    expect_busy();
    expect_pulse();
    add_row("fence_i_both_done", w);
    give_done(2'b11);
    expect_busy();
    add_row("fence_i_second_release", w);

    // flush
    add_row("add_before_flush", r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd29, decode_pkg::OPC_OP));
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd29, last_rs1(), last_rs2());
    add_row("lw_before_flush", i_type(12'h004, 5'd2, 3'b010, 5'd30, decode_pkg::OPC_LOAD));
    stall_units(4'b1000);
    slot_is(decode_pkg::FU_LS, 4'b0010, 5'd30, last_rs1(), 32'h0000_0004);
    also_valid(decode_pkg::FU_ARITH);
    w = r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd31, decode_pkg::OPC_OP);
    add_row("flush_all_stalled", w);
    stall_units(4'b1111);
    raise_flush();
    expect_busy();
    add_row("add_after_flush", w);
    slot_is(decode_pkg::FU_ARITH, 4'b0000, 5'd31, last_rs1(), last_rs2());
    add_row("flush_drops_add", r_type(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, decode_pkg::OPC_OP));
    raise_flush();
    add_row("unknown_opcode", 32'h1234_507f);
  endtask

  initial begin
    void'($urandom(74));
    nRST = 1'b0;
    fetch = '0;
    rs1_data = '0;
    rs2_data = '0;
    bypass = '0;
    unit_stall = '0;
    flush = 1'b0;
    flush_done = '0;
    error_count = 0;
    n_rows = 0;
    build_table();
    cycle_limit = 4 * n_rows + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    compare("reset", "slot valid bits", 128'(0),
            128'({issue.arith.valid, issue.mul.valid, issue.div.valid, issue.ls.valid}));
    compare("reset", "cache_flush", 128'(0), 128'(cache_flush));

    // slots of row i are seen one edge after it is applied
    for (int i = 0; i < n_rows; i++) begin
      @(posedge CLK);
      apply_row(rows[i]);
      @(negedge CLK);
      compare(names[i], "decode_busy", 128'(rows[i].exp_busy), 128'(decode_busy));
      compare(names[i], "cache_flush", 128'(rows[i].exp_cf), 128'(cache_flush));
      // register file indices sit in the RV32 rs1 and rs2 fields
      compare(names[i], "rs1", 128'(rows[i].instr[19:15]), 128'(rs1_idx));
      compare(names[i], "rs2", 128'(rows[i].instr[24:20]), 128'(rs2_idx));
      if (i > 0) begin
        check_slots(i - 1);
      end
    end
    @(posedge CLK);
    @(negedge CLK);
    check_slots(n_rows - 1);

    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
